// File: tb.f
+incdir+logic
logic/spi_pkg.sv
logic/spi_sck_gen.sv
logic/spi_tx_shift.sv
logic/spi_rx_shift.sv
logic/spi_char_trx.sv
verification/spi_clk_src.sv
verification/spi_trx_checker.sv
verification/spi_trx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the SPI transceiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spi_trx_tb -f tb.f -o spi_trx_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/spi_trx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi

// File: verification/spi_trx_tb.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_trx_tb;

    localparam logic [1:0] K_PLAIN  = 2'd0;
    localparam logic [1:0] K_IGNORE = 2'd1;     // extra starts that must do nothing
    localparam logic [1:0] K_ABORT  = 2'd2;

    typedef struct packed {
        spi_pkg::spi_cfg_t  cfg;
        spi_pkg::spi_char_t wchar;
        spi_pkg::spi_char_t miso_char;
        spi_pkg::spi_char_t exp_rchar;
        spi_pkg::spi_char_t exp_mosi;
        logic [1:0]         kind;
    } row_t;

    logic               S_CHAR_GO;
    logic               S_RESETN;
    logic               enable;
    spi_pkg::spi_cfg_t  cfg;
    logic               start;
    spi_pkg::spi_char_t wchar;
    spi_pkg::spi_char_t rchar;
    logic               done;
    logic               busy;
    logic               sck;
    logic               miso;
    logic               mosi;

    row_t               rows[$];
    row_t               cur;
    logic [31:0]        lfsr;
    int                 len_bits;
    int                 tx_idx;
    int                 rx_idx;
    int                 lead_cnt;
    logic               prev_sck;
    spi_pkg::spi_char_t slv_rx;             // what the slave saw on mosi

    spi_clk_src u_clk (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN)
    );

    spi_char_trx dut (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .enable    (enable),
        .cfg       (cfg),
        .start     (start),
        .wchar     (wchar),
        .rchar     (rchar),
        .done      (done),
        .busy      (busy),
        .sck       (sck),
        .miso      (miso),
        .mosi      (mosi)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic spi_pkg::spi_char_t rand_bits(input int n);
        spi_pkg::spi_char_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    function automatic spi_pkg::spi_char_t char_mask(input int n);
        spi_pkg::spi_char_t m;
        for (int i = 0; i < `SPI_CHAR_NBITS; i++) begin
            m[i] = (i < n);
        end
        return m;
    endfunction

    // k-th bit on the wire
    function automatic int bit_pos(input int k);
        return cur.cfg.lsb_first ? k : len_bits - 1 - k;
    endfunction

    function automatic void add_row(input logic cpol, input logic cpha, input logic lsb,
                                    input logic loop, input int len, input int div,
                                    input logic [1:0] kind);
        row_t r;
        r.cfg.cpol      = cpol;
        r.cfg.cpha      = cpha;
        r.cfg.lsb_first = lsb;
        r.cfg.loop      = loop;
        r.cfg.char_len  = spi_pkg::spi_len_t'(len - 1);
        r.cfg.divider   = spi_pkg::spi_div_t'(div);
        r.wchar         = rand_bits(32);        // upper bits must be ignored
        r.miso_char     = rand_bits(32);
        r.exp_mosi      = r.wchar & char_mask(len);
        r.exp_rchar     = (loop ? r.wchar : r.miso_char) & char_mask(len);
        r.kind          = kind;
        rows.push_back(r);
    endfunction

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_char(input string name, input spi_pkg::spi_char_t got,
                              input spi_pkg::spi_char_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic wait_for_done(input int limit);
        int n;
        n = 0;
        while (!done) begin
            @(negedge S_CHAR_GO);
            n++;
            if (n > limit) begin
                stop_on_failure("timed out waiting for done");
            end
        end
    endtask

    task automatic quiet_cycles(input int n);
        repeat (n) begin
            @(negedge S_CHAR_GO);
            check_bit("done", done, 1'b0);
            check_bit("busy", busy, 1'b0);
        end
    endtask

    // slave acts half a clock after each sck edge
    always @(negedge S_CHAR_GO) begin
        if (busy && enable && sck !== prev_sck) begin
            if (sck != cur.cfg.cpol) begin
                lead_cnt++;
                if (cur.cfg.cpha) begin
                    if (tx_idx < len_bits) miso = cur.miso_char[bit_pos(tx_idx)];
                    tx_idx++;
                end else if (rx_idx < len_bits) begin
                    slv_rx[bit_pos(rx_idx)] = mosi;
                    rx_idx++;
                end
            end else if (cur.cfg.cpha) begin
                if (rx_idx < len_bits) begin
                    slv_rx[bit_pos(rx_idx)] = mosi;
                    rx_idx++;
                end
            end else begin
                tx_idx++;
                if (tx_idx < len_bits) miso = cur.miso_char[bit_pos(tx_idx)];
            end
        end
        prev_sck = sck;
    end

    task automatic run_row(input row_t r);
        int div;
        @(negedge S_CHAR_GO);
        cfg    = r.cfg;
        wchar  = r.wchar;
        enable = 1'b1;
        repeat (2) @(negedge S_CHAR_GO);    // sck settles to the new cpol
        cur      = r;
        len_bits = int'(r.cfg.char_len) + 1;
        div      = int'(r.cfg.divider) + 1;
        tx_idx   = 0;
        rx_idx   = 0;
        lead_cnt = 0;
        slv_rx   = '0;
        miso     = r.miso_char[bit_pos(0)];
        start    = 1'b1;
        @(negedge S_CHAR_GO);
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
        if (r.kind == K_ABORT) begin
            repeat (len_bits * div) @(negedge S_CHAR_GO);
            enable = 1'b0;
            @(negedge S_CHAR_GO);
            check_bit("busy", busy, 1'b0);
            check_bit("done", done, 1'b0);
            quiet_cycles(4);
            enable = 1'b1;
            return;
        end
        if (r.kind == K_IGNORE) begin
            repeat (3) @(negedge S_CHAR_GO);
            wchar = ~r.wchar;
            start = 1'b1;
            @(negedge S_CHAR_GO);
            start = 1'b0;
            wchar = r.wchar;
        end
        wait_for_done(2 * len_bits * div + 12);
        check_char("rchar", rchar, r.exp_rchar);
        check_char("slave mosi char", slv_rx, r.exp_mosi);
        check_count("sck periods", lead_cnt, len_bits);
        check_bit("sck", sck, r.cfg.cpol);
        @(negedge S_CHAR_GO);
        check_bit("done", done, 1'b0);
        check_bit("busy", busy, 1'b0);
        if (r.kind == K_IGNORE) begin
            quiet_cycles(4 * div + 4);
            enable = 1'b0;
            start  = 1'b1;
            @(negedge S_CHAR_GO);
            start = 1'b0;
            quiet_cycles(4);
            check_char("rchar", rchar, r.exp_rchar);
            enable = 1'b1;
        end
    endtask

    initial begin
        int n;
        cfg      = '0;
        enable   = 1'b0;
        start    = 1'b0;
        wchar    = '0;
        miso     = 1'b1;
        prev_sck = 1'b0;
        lfsr     = 32'd83166;
        for (int m = 0; m < 8; m++) begin
            add_row(m[0], m[1], m[2], 1'b1, 3 + 4 * m, m % 3, K_PLAIN);
        end
        add_row(1'b0, 1'b0, 1'b1, 1'b0, 1, 0, K_PLAIN);
        add_row(1'b1, 1'b0, 1'b0, 1'b0, 8, 1, K_PLAIN);
        add_row(1'b0, 1'b1, 1'b0, 1'b0, 16, 2, K_PLAIN);
        add_row(1'b1, 1'b1, 1'b1, 1'b0, 32, 3, K_PLAIN);
        add_row(1'b0, 1'b1, 1'b0, 1'b0, 12, 1, K_IGNORE);
        add_row(1'b1, 1'b0, 1'b1, 1'b0, 16, 2, K_ABORT);
        add_row(1'b1, 1'b1, 1'b0, 1'b0, 24, 1, K_PLAIN);
        n = 0;
        while (S_RESETN !== 1'b1) begin
            @(negedge S_CHAR_GO);
            n++;
            if (n > 20) begin
                stop_on_failure("reset never released");
            end
        end
        check_char("rchar", rchar, '1);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("sck", sck, 1'b0);
        check_bit("mosi", mosi, 1'b1);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        repeat (5) @(negedge S_CHAR_GO);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: verification/spi_trx_checker.sv
`timescale 1ns/1ps

module spi_trx_checker (
    input logic              S_CHAR_GO,
    input logic              S_RESETN,
    input logic              enable,
    input spi_pkg::spi_cfg_t cfg,
    input logic              done,
    input logic              busy,
    input logic              sck,
    input logic              mosi
);

    done_single: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN)
        done |=> !done)
        else $error("done held for more than one cycle");

    // an abort drops busy without done, so only check with enable high
    busy_drop: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN || !enable)
        $fell(busy) |-> done)
        else $error("busy fell without done");

    sck_rest: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN || !enable)
        (!busy && $past(!busy)) |-> (sck == $past(cfg.cpol)))
        else $error("sck left its rest level while idle");

    mosi_idle: assert property (@(posedge S_CHAR_GO) disable iff (!S_RESETN || !enable)
        (!busy && $past(!busy)) |-> $stable(mosi))
        else $error("mosi moved while idle");

endmodule

bind spi_char_trx spi_trx_checker u_checker (
    .S_CHAR_GO (S_CHAR_GO),
    .S_RESETN  (S_RESETN),
    .enable    (enable),
    .cfg       (cfg),
    .done      (done),
    .busy      (busy),
    .sck       (sck),
    .mosi      (mosi)
);

// File: verification/spi_clk_src.sv
`timescale 1ns/1ps

module spi_clk_src (
    output logic S_CHAR_GO,
    output logic S_RESETN
);

    initial begin
        S_CHAR_GO = 1'b0;
        forever #20 S_CHAR_GO = ~S_CHAR_GO;     // 40 ns period
    end

    initial begin
        S_RESETN = 1'b0;
        repeat (10) @(posedge S_CHAR_GO);
        @(negedge S_CHAR_GO);
        S_RESETN = 1'b1;                        // release away from the active edge
    end

endmodule

// File: logic/spi_char_trx.sv
`timescale 1ns/1ps

module spi_char_trx (
    input  logic               S_CHAR_GO,
    input  logic               S_RESETN,
    input  logic               enable,
    input  spi_pkg::spi_cfg_t  cfg,
    input  logic               start,
    input  spi_pkg::spi_char_t wchar,
    output spi_pkg::spi_char_t rchar,
    output logic               done,
    output logic               busy,
    output logic               sck,
    input  logic               miso,
    output logic               mosi
);

    spi_pkg::spi_state_t state;
    spi_pkg::spi_cfg_t   cfg_q;
    spi_pkg::spi_cfg_t   cfg_cur;
    spi_pkg::spi_len_t   bit_cnt;
    logic                tail;
    logic                accept;
    logic                load;
    logic                run;
    logic                launch;
    logic                sample;
    logic                capture;
    logic                tx_launch;
    logic                rx_bit;
    logic                last_bit;
    logic                last_edge;

    assign busy      = (state != spi_pkg::idle);
    assign accept    = start && enable && !busy;
    assign load      = accept;
    assign last_edge = cfg_q.cpha ? (sample && last_bit) : (launch && tail);
    assign run       = (state == spi_pkg::shift) && !last_edge;  // no sck edge past the last one
    assign capture   = (state == spi_pkg::finish) && enable;
    assign cfg_cur   = busy ? cfg_q : cfg;               // live config until a start
    assign last_bit  = (bit_cnt == cfg_q.char_len);
    assign rx_bit    = cfg_cur.loop ? mosi : miso;

    // first bit is already out at load, so cpha 1 drops its first launch;
    // capture pushes mosi back to idle high
    assign tx_launch = (launch && !(cfg_q.cpha && bit_cnt == '0)) || capture;

    always_ff @(posedge S_CHAR_GO) begin
        if (accept) begin
            cfg_q <= cfg;
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state   <= spi_pkg::idle;
            bit_cnt <= '0;
            tail    <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= capture;
            if (!enable) begin
                state <= spi_pkg::idle;              // abort, no done
                tail  <= 1'b0;
            end else begin
                case (state)
                    spi_pkg::idle: begin
                        if (accept) begin
                            state   <= spi_pkg::shift;
                            bit_cnt <= '0;
                            tail    <= 1'b0;
                        end
                    end
                    spi_pkg::shift: begin
                        if (sample) begin
                            if (!last_bit) begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end else if (cfg_q.cpha) begin
                                state <= spi_pkg::finish;
                            end else begin
                                tail <= 1'b1;        // wait out the trailing edge
                            end
                        end
                        if (launch && tail) begin
                            state <= spi_pkg::finish;
                        end
                    end
                    spi_pkg::finish: begin
                        state <= spi_pkg::idle;
                        tail  <= 1'b0;
                    end
                    default: begin
                        state <= spi_pkg::idle;
                    end
                endcase
            end
        end
    end

    spi_sck_gen u_sck_gen (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .run       (run),
        .cpol      (cfg_cur.cpol),
        .cpha      (cfg_cur.cpha),
        .divider   (cfg_cur.divider),
        .sck       (sck),
        .launch    (launch),
        .sample    (sample)
    );

    spi_tx_shift u_tx_shift (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .load      (load),
        .launch    (tx_launch),
        .lsb_first (cfg_cur.lsb_first),
        .char_len  (cfg_cur.char_len),
        .wchar     (wchar),
        .mosi      (mosi)
    );

    spi_rx_shift u_rx_shift (
        .S_CHAR_GO (S_CHAR_GO),
        .S_RESETN  (S_RESETN),
        .sample    (sample),
        .capture   (capture),
        .rx_bit    (rx_bit),
        .lsb_first (cfg_cur.lsb_first),
        .char_len  (cfg_cur.char_len),
        .rchar     (rchar)
    );

endmodule

// File: logic/spi_rx_shift.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_rx_shift (
    input  logic               S_CHAR_GO,
    input  logic               S_RESETN,
    input  logic               sample,
    input  logic               capture,
    input  logic               rx_bit,
    input  logic               lsb_first,
    input  spi_pkg::spi_len_t  char_len,
    output spi_pkg::spi_char_t rchar
);

    spi_pkg::spi_char_t shreg;
    spi_pkg::spi_char_t aligned;

    // lsb-first bits pile up at the top and must come down
    always_comb begin
        if (lsb_first) begin
            aligned = shreg >> (`SPI_CHAR_NBITS - 1 - char_len);
        end else begin
            aligned = shreg;
        end
    end

    always_ff @(posedge S_CHAR_GO) begin
        if (sample) begin
            if (lsb_first) begin
                shreg <= {rx_bit, shreg[`SPI_CHAR_NBITS-1:1]};
            end else begin
                shreg <= {shreg[`SPI_CHAR_NBITS-2:0], rx_bit};
            end
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            rchar <= '1;
        end else if (capture) begin
            rchar <= aligned & spi_pkg::len_mask(char_len);  // stale upper bits cleared
        end
    end

endmodule

// File: logic/spi_tx_shift.sv
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_tx_shift (
    input  logic               S_CHAR_GO,
    input  logic               S_RESETN,
    input  logic               load,
    input  logic               launch,
    input  logic               lsb_first,
    input  spi_pkg::spi_len_t  char_len,
    input  spi_pkg::spi_char_t wchar,
    output logic               mosi
);

    spi_pkg::spi_char_t shreg;
    spi_pkg::spi_char_t shreg_nxt;

    // bits past the character are ones, so mosi drifts high once it is sent
    always_comb begin
        if (load) begin
            shreg_nxt = wchar | ~spi_pkg::len_mask(char_len);
        end else if (lsb_first) begin
            shreg_nxt = {1'b1, shreg[`SPI_CHAR_NBITS-1:1]};
        end else begin
            shreg_nxt = {shreg[`SPI_CHAR_NBITS-2:0], 1'b1};
        end
    end

    always_ff @(posedge S_CHAR_GO) begin
        if (load || launch) begin
            shreg <= shreg_nxt;
        end
    end

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            mosi <= 1'b1;
        end else if (load || launch) begin
            if (lsb_first) begin
                mosi <= shreg_nxt[0];
            end else begin
                mosi <= shreg_nxt[char_len];             // msb sits at the length index
            end
        end
    end

endmodule

// File: logic/spi_sck_gen.sv
`timescale 1ns/1ps

module spi_sck_gen (
    input  logic              S_CHAR_GO,
    input  logic              S_RESETN,
    input  logic              run,
    input  logic              cpol,
    input  logic              cpha,
    input  spi_pkg::spi_div_t divider,
    output logic              sck,
    output logic              launch,
    output logic              sample
);

    spi_pkg::spi_div_t half_cnt;
    logic              expire;
    logic              leading;

    assign expire  = run && (half_cnt == divider);   // sck toggles on the next edge
    assign leading = (sck == cpol);                  // leaving the rest level

    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            half_cnt <= '0;
            sck      <= 1'b0;
        end else if (!run) begin
            half_cnt <= '0;
            sck      <= cpol;                        // park at rest level
        end else if (expire) begin
            half_cnt <= '0;
            sck      <= ~sck;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // cpha 0 samples on the leading edge, cpha 1 launches on it
    always_ff @(posedge S_CHAR_GO or negedge S_RESETN) begin
        if (!S_RESETN) begin
            launch <= 1'b0;
            sample <= 1'b0;
        end else begin
            launch <= expire && (leading == cpha);
            sample <= expire && (leading != cpha);
        end
    end

endmodule

// File: logic/spi_pkg.sv
`include "spi_settings.svh"

package spi_pkg;

    typedef logic [`SPI_CHAR_NBITS-1:0] spi_char_t;
    typedef logic [`SPI_LEN_NBITS-1:0]  spi_len_t;   // length - 1, also bit index
    typedef logic [`SPI_DIV_NBITS-1:0]  spi_div_t;

    typedef struct packed {
        logic     cpol;
        logic     cpha;
        logic     lsb_first;
        logic     loop;       // sample mosi instead of miso
        spi_len_t char_len;
        spi_div_t divider;
    } spi_cfg_t;

    typedef enum logic [1:0] {
        idle,
        shift,
        finish
    } spi_state_t;

    // ones in the low len + 1 bits
    function automatic spi_char_t len_mask(input spi_len_t len);
        return {`SPI_CHAR_NBITS{1'b1}} >> (`SPI_CHAR_NBITS - 1 - len);
    endfunction

endpackage

// File: logic/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// widest character the transceiver can move
`define SPI_CHAR_NBITS 32

// length field holds the length minus one
`define SPI_LEN_NBITS 5

// each sck half period is divider + 1 clocks
`define SPI_DIV_NBITS 10

`endif
